// File: list.f
+incdir+.
cache_pkg.sv
cache_level.sv
level_counters.sv
cache_controller.sv
cache_hierarchy.sv
tb_cache_hierarchy.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_cache_hierarchy -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_cache_hierarchy.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module tb_cache_hierarchy
  import cache_pkg::*;
;

  localparam int BLOCK   = 1 << `BLOCK_BITS;
  localparam int POOL    = 48;
  localparam int TIMEOUT = 20;

  logic               clk;
  logic               reset;
  logic               req_valid;
  logic [`ADDR_W-1:0] req_addr;
  logic [7:0]         req_op;
  logic               replace_lru;
  logic               write_back;
  logic               busy;
  logic               done;
  logic               l1_hit;
  logic               l2_hit;
  level_stats_t       l1_stats;
  level_stats_t       l2_stats;

  // Reference tag lists, index 0 of a level is L1, way 0 is newest
  logic [31:0]  m_tag [2][`L2_SETS][`L2_WAYS];
  bit           m_val [2][`L2_SETS][`L2_WAYS];
  level_stats_t exp_l1;
  level_stats_t exp_l2;
  logic         exp_l1_hit;
  logic         exp_l2_hit;
  bit           cur_lru;
  bit           cur_wb;

  logic [31:0] rng;
  logic [31:0] pool [POOL];
  int          errors;
  int          start_errors;
  int          tests_run;
  int          tests_ok;

  cache_hierarchy i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_op      (req_op),
    .replace_lru (replace_lru),
    .write_back  (write_back),
    .busy        (busy),
    .done        (done),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .l1_stats    (l1_stats),
    .l2_stats    (l2_stats)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random source and checks
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_stats(input string name, input level_stats_t got,
                             input level_stats_t exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int level_sets(input int lvl);
    return (lvl == 0) ? `L1_SETS : `L2_SETS;
  endfunction

  function automatic int level_ways(input int lvl);
    return (lvl == 0) ? `L1_WAYS : `L2_WAYS;
  endfunction

  // Set is (addr / block) mod sets, tag is addr / (block * sets)
  function automatic int set_of(input int lvl, input logic [31:0] addr);
    return int'((addr / BLOCK) % level_sets(lvl));
  endfunction

  function automatic logic [31:0] tag_of(input int lvl, input logic [31:0] addr);
    return addr / (BLOCK * level_sets(lvl));
  endfunction

  // Way holding the tag, or -1 on a miss
  function automatic int find_way(input int lvl, input logic [31:0] addr);
    int idx;
    int hit_way;
    idx = set_of(lvl, addr);
    hit_way = -1;
    for (int w = 0; w < level_ways(lvl); w++) begin
      if (hit_way < 0 && m_val[lvl][idx][w] && m_tag[lvl][idx][w] == tag_of(lvl, addr)) begin
        hit_way = w;
      end
    end
    return hit_way;
  endfunction

  // Fill is a move from the oldest way, which drops that entry
  task automatic move_to_front(input int lvl, input logic [31:0] addr, input int way);
    int idx;
    idx = set_of(lvl, addr);
    for (int w = way; w > 0; w--) begin
      m_tag[lvl][idx][w] = m_tag[lvl][idx][w-1];
      m_val[lvl][idx][w] = m_val[lvl][idx][w-1];
    end
    m_tag[lvl][idx][0] = tag_of(lvl, addr);
    m_val[lvl][idx][0] = 1'b1;
  endtask

  task automatic model_access(input logic [31:0] addr, input logic wr);
    int h1;
    int h2;
    h1 = find_way(0, addr);
    h2 = find_way(1, addr);
    exp_l1_hit = (h1 >= 0);
    exp_l2_hit = (h2 >= 0);
    exp_l1.reads++;
    if (h1 >= 0) begin
      exp_l1.hits++;
      if (cur_lru) begin
        move_to_front(0, addr, h1);
      end
    end else begin
      exp_l1.misses++;
      exp_l2.reads++;
      move_to_front(0, addr, level_ways(0) - 1);
      if (h2 >= 0) begin
        exp_l2.hits++;
        if (cur_lru) begin
          move_to_front(1, addr, h2);
        end
      end else begin
        exp_l2.misses++;
        move_to_front(1, addr, level_ways(1) - 1);
      end
    end
    // Write-back keeps L1 write hits out of L2
    if (wr) begin
      exp_l1.writes++;
      if (!cur_wb || h1 < 0) begin
        exp_l2.writes++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic reset_dut(input bit lru, input bit wb);
    @(posedge clk);
    reset       <= 1'b1;
    req_valid   <= 1'b0;
    replace_lru <= lru;
    write_back  <= wb;
    cur_lru = lru;
    cur_wb  = wb;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    m_val  = '{default: 1'b0};
    exp_l1 = '0;
    exp_l2 = '0;
    @(negedge clk);
  endtask

  // One access, optionally with a second strobe while busy
  task automatic run_access(input logic [31:0] addr, input logic wr, input bit extra_req);
    int cycles;
    model_access(addr, wr);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_op    <= wr ? `OP_WRITE : `OP_READ;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      req_valid <= extra_req && (cycles == 1);
      // A stray strobe carries another address and the other op
      if (extra_req && cycles == 1) begin
        req_addr <= ~addr;
        req_op   <= wr ? `OP_READ : `OP_WRITE;
      end
      @(negedge clk);
    end while (!done && cycles < TIMEOUT);
    if (!done) begin
      $display("access to %h never raised done within %0d cycles", addr, TIMEOUT);
      $display("tests failed");
      $finish;
    end else begin
      assert (cycles == 3) else begin
        $display("done came %0d cycles after the request instead of 3", cycles);
        errors++;
      end
      check_flag("l1_hit", l1_hit, exp_l1_hit);
      check_flag("l2_hit", l2_hit, exp_l2_hit);
      check_stats("l1_stats", l1_stats, exp_l1);
      check_stats("l2_stats", l2_stats, exp_l2);
      @(posedge clk);
      @(negedge clk);
      assert (!done && !busy) else begin
        $display("done or busy still high one cycle after done for %h", addr);
        errors++;
      end
    end
  endtask

  task automatic run_random(input int count);
    int sel;
    for (int n = 0; n < count; n++) begin
      rng = xorshift32(rng);
      sel = int'(rng % POOL);
      run_access(pool[sel], rng[8], 1'b0);
    end
  endtask

  // A, B, A, C, A in one L1 set
  task automatic run_order_case(input bit lru);
    logic [31:0] a;
    a = 32'h0001_2040;
    reset_dut(lru, 1'b0);
    run_access(a, 1'b0, 1'b0);
    run_access(a + 32'h400, 1'b0, 1'b0);
    run_access(a, 1'b0, 1'b0);
    run_access(a + 32'h800, 1'b0, 1'b0);
    run_access(a, 1'b0, 1'b0);
    check_flag("l1_hit", l1_hit, lru);
    check_flag("l2_hit", l2_hit, 1'b1);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == start_errors) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
    end
    start_errors = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_op      = `OP_READ;
    replace_lru = 1'b0;
    write_back  = 1'b0;
    errors       = 0;
    start_errors = 0;
    tests_run    = 0;
    tests_ok     = 0;
    rng = 32'hb4d1;
    // Eight sets per level in use, so both levels see hits and evictions
    for (int i = 0; i < POOL; i++) begin
      rng = xorshift32(rng);
      pool[i] = rng & 32'h0003_f1c0;
    end

    reset_dut(1'b0, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("l1_hit", l1_hit, 1'b0);
    check_flag("l2_hit", l2_hit, 1'b0);
    check_stats("l1_stats", l1_stats, '0);
    check_stats("l2_stats", l2_stats, '0);
    rng = xorshift32(rng);
    run_access(rng, 1'b0, 1'b0);
    check_flag("l1_hit", l1_hit, 1'b0);
    check_flag("l2_hit", l2_hit, 1'b0);
    finish_test("reset state and first access");

    reset_dut(1'b0, 1'b0);
    run_random(300);
    finish_test("fifo write-through random");

    reset_dut(1'b1, 1'b1);
    run_random(300);
    finish_test("lru write-back random");

    run_order_case(1'b1);
    run_order_case(1'b0);
    finish_test("eviction order lru and fifo");

    // Second strobe lands in the lookup cycle
    reset_dut(1'b0, 1'b0);
    run_access(pool[0], 1'b0, 1'b0);
    run_access(pool[1], 1'b1, 1'b1);
    // Two accesses since reset, one read each
    assert (l1_stats.reads === `STAT_W'(2)) else begin
      $display("Fail l1_stats.reads: got %h expected %h", l1_stats.reads, `STAT_W'(2));
      errors++;
    end
    finish_test("request while busy ignored");

    reset_dut(1'b1, 1'b0);
    for (int n = 0; n < 40; n++) begin
      rng = xorshift32(rng);
      run_access(pool[int'(rng % POOL)], rng[3], rng[9]);
    end
    finish_test("done latency and width");

    $display("summary: %0d tests run, %0d passed, %0d check errors",
             tests_run, tests_ok, errors);
    if (errors == 0 && tests_ok == tests_run) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: cache_hierarchy.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_hierarchy
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  input  logic [`ADDR_W-1:0] req_addr,
  input  logic [7:0]         req_op,
  input  logic               replace_lru,
  input  logic               write_back,
  output logic               busy,
  output logic               done,
  output logic               l1_hit,
  output logic               l2_hit,
  output level_stats_t       l1_stats,
  output level_stats_t       l2_stats
);

  // Shared request and strobes
  access_req_t  access;
  logic         lookup;
  logic         update;
  // Per-level command, result and event
  update_cmd_e  l1_cmd;
  update_cmd_e  l2_cmd;
  logic         l1_found;
  logic         l2_found;
  level_event_t l1_evt;
  level_event_t l2_evt;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  cache_controller i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_op      (req_op),
    .replace_lru (replace_lru),
    .write_back  (write_back),
    .l1_found    (l1_found),
    .l2_found    (l2_found),
    .access      (access),
    .lookup      (lookup),
    .update      (update),
    .l1_cmd      (l1_cmd),
    .l2_cmd      (l2_cmd),
    .l1_evt      (l1_evt),
    .l2_evt      (l2_evt),
    .busy        (busy),
    .done        (done),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit)
  );

  //////////////////////////////////////////////////
  // Tag stores searched in parallel
  //////////////////////////////////////////////////

  cache_level #(
    .NUM_SETS (`L1_SETS),
    .WAYS     (`L1_WAYS)
  ) i_l1 (
    .clk    (clk),
    .reset  (reset),
    .access (access),
    .lookup (lookup),
    .update (update),
    .cmd    (l1_cmd),
    .found  (l1_found)
  );

  cache_level #(
    .NUM_SETS (`L2_SETS),
    .WAYS     (`L2_WAYS)
  ) i_l2 (
    .clk    (clk),
    .reset  (reset),
    .access (access),
    .lookup (lookup),
    .update (update),
    .cmd    (l2_cmd),
    .found  (l2_found)
  );

  // Statistics per level
  level_counters i_l1_cnt (
    .clk   (clk),
    .reset (reset),
    .evt   (l1_evt),
    .stats (l1_stats)
  );

  level_counters i_l2_cnt (
    .clk   (clk),
    .reset (reset),
    .evt   (l2_evt),
    .stats (l2_stats)
  );

endmodule

// File: cache_controller.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_controller
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  input  logic [`ADDR_W-1:0] req_addr,
  input  logic [7:0]         req_op,
  input  logic               replace_lru,
  input  logic               write_back,
  input  logic               l1_found,
  input  logic               l2_found,
  output access_req_t        access,
  output logic               lookup,
  output logic               update,
  output update_cmd_e        l1_cmd,
  output update_cmd_e        l2_cmd,
  output level_event_t       l1_evt,
  output level_event_t       l2_evt,
  output logic               busy,
  output logic               done,
  output logic               l1_hit,
  output logic               l2_hit
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_UPDATE,
    S_DONE
  } state_e;

  state_e state;
  state_e next_state;
  logic   accept;

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  // Requests while busy are dropped
  assign accept = req_valid && (state == S_IDLE);

  // Fixed walk through lookup, update and done
  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (accept) begin
          next_state = S_LOOKUP;
        end
      end
      S_LOOKUP: next_state = S_UPDATE;
      S_UPDATE: next_state = S_DONE;
      default:  next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Capture the access and decode the op code once
  always_ff @(posedge clk) begin
    if (accept) begin
      access.addr     <= req_addr;
      access.is_write <= (req_op == `OP_WRITE);
    end
  end

  assign lookup = (state == S_LOOKUP);
  assign update = (state == S_UPDATE);
  assign busy   = (state != S_IDLE);
  assign done   = (state == S_DONE);

  //////////////////////////////////////////////////
  // Policy decisions at update
  //////////////////////////////////////////////////

  always_comb begin
    l1_cmd = UPD_NONE;
    l2_cmd = UPD_NONE;
    l1_evt = '0;
    l2_evt = '0;
    if (update) begin
      // L1 sees every access
      l1_evt.read  = 1'b1;
      l1_evt.hit   = l1_found;
      l1_evt.miss  = !l1_found;
      l1_evt.write = access.is_write;
      // L2 only counts the L1 misses it serves
      l2_evt.read  = !l1_found;
      l2_evt.hit   = !l1_found && l2_found;
      l2_evt.miss  = !l1_found && !l2_found;
      // Write-back holds L1 write hits away from L2
      l2_evt.write = access.is_write && (!write_back || !l1_found);
      if (!l1_found) begin
        l1_cmd = UPD_FILL;
      end else if (replace_lru) begin
        l1_cmd = UPD_PROMOTE;
      end
      // L2 order is left alone when L1 hits
      if (!l1_found) begin
        if (!l2_found) begin
          l2_cmd = UPD_FILL;
        end else if (replace_lru) begin
          l2_cmd = UPD_PROMOTE;
        end
      end
    end
  end

  // Hit flags for the finished access
  always_ff @(posedge clk) begin
    if (reset) begin
      l1_hit <= 1'b0;
      l2_hit <= 1'b0;
    end else if (update) begin
      l1_hit <= l1_found;
      l2_hit <= l2_found;
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (reset)
    done |=> !done);

  // Only the two known op codes start an access
  a_legal_op: assert property (@(posedge clk) disable iff (reset)
    accept |-> (req_op == `OP_READ) || (req_op == `OP_WRITE));

endmodule

// File: level_counters.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module level_counters
  import cache_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  level_event_t evt,
  output level_stats_t stats
);

  // Step by one and stick at all ones
  function automatic logic [`STAT_W-1:0] sat_inc(
    input logic [`STAT_W-1:0] value,
    input logic               en
  );
    if (en && (value != '1)) begin
      return value + 1'b1;
    end
    return value;
  endfunction

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////

  // Each flag of the event bumps its own counter
  always_ff @(posedge clk) begin
    if (reset) begin
      stats <= '0;
    end else begin
      stats.reads  <= sat_inc(stats.reads, evt.read);
      stats.hits   <= sat_inc(stats.hits, evt.hit);
      stats.misses <= sat_inc(stats.misses, evt.miss);
      stats.writes <= sat_inc(stats.writes, evt.write);
    end
  end

  // Hit and miss are exclusive within one access
  a_hit_miss_excl: assert property (@(posedge clk) disable iff (reset)
    !(evt.hit && evt.miss));

endmodule

// File: cache_level.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_level
  import cache_pkg::*;
#(
  parameter int NUM_SETS = 16,
  parameter int WAYS     = 2
) (
  input  logic        clk,
  input  logic        reset,
  input  access_req_t access,
  input  logic        lookup,
  input  logic        update,
  input  update_cmd_e cmd,
  output logic        found
);

  // Set count is a power of two so the index is a plain bit slice
  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = `ADDR_W - `BLOCK_BITS - IDX_W;
  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  // Tag store, way 0 is the newest entry of a set
  logic [TAG_W-1:0]              tags [NUM_SETS][WAYS];
  logic [NUM_SETS-1:0][WAYS-1:0] valid;

  logic [IDX_W-1:0] idx_in;
  logic [IDX_W-1:0] idx_q;
  logic [TAG_W-1:0] tag_in;
  logic [TAG_W-1:0] tag_q;
  logic [WAY_W-1:0] way_in;
  logic [WAY_W-1:0] way_q;
  logic             hit_in;
  logic [WAYS-1:0]  shift_en;
  logic             set_dup;

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  // Index is (addr / block) mod sets
  assign idx_in = access.addr[`BLOCK_BITS +: IDX_W];
  // Tag is addr / (block * sets)
  assign tag_in = access.addr[`ADDR_W-1 -: TAG_W];

  // Compare every valid way of the addressed set
  always_comb begin
    hit_in = 1'b0;
    way_in = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (valid[idx_in][w] && (tags[idx_in][w] == tag_in)) begin
        hit_in = 1'b1;
        way_in = WAY_W'(w);
      end
    end
  end

  // Hold set, tag and hit way for the update cycle
  always_ff @(posedge clk) begin
    if (lookup) begin
      idx_q <= idx_in;
      tag_q <= tag_in;
      way_q <= way_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      found <= 1'b0;
    end else if (lookup) begin
      found <= hit_in;
    end
  end

  //////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////

  // Way 0 takes the tag on any command
  // Fill ages every way while promote ages only ways up to the hit way
  always_comb begin
    shift_en    = '0;
    shift_en[0] = update && (cmd != UPD_NONE);
    for (int w = 1; w < WAYS; w++) begin
      shift_en[w] = update && ((cmd == UPD_FILL) ||
                               ((cmd == UPD_PROMOTE) && (WAY_W'(w) <= way_q)));
    end
  end

  // Tags move one way older and the oldest falls out on fill
  always_ff @(posedge clk) begin
    for (int w = WAYS - 1; w > 0; w--) begin
      if (shift_en[w]) begin
        tags[idx_q][w] <= tags[idx_q][w-1];
      end
    end
    if (shift_en[0]) begin
      tags[idx_q][0] <= tag_q;
    end
  end

  // Valid bits follow their tags
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else begin
      for (int w = WAYS - 1; w > 0; w--) begin
        if (shift_en[w]) begin
          valid[idx_q][w] <= valid[idx_q][w-1];
        end
      end
      if (shift_en[0]) begin
        valid[idx_q][0] <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Duplicate detection on the set last touched
  always_comb begin
    set_dup = 1'b0;
    for (int a = 0; a < WAYS; a++) begin
      for (int b = a + 1; b < WAYS; b++) begin
        if (valid[idx_q][a] && valid[idx_q][b] && (tags[idx_q][a] == tags[idx_q][b])) begin
          set_dup = 1'b1;
        end
      end
    end
  end

  // An updated set never ends up holding one tag twice
  a_no_dup_tag: assert property (@(posedge clk) disable iff (reset)
    update |=> !set_dup);

  // Controller only promotes a way this level reported as hit
  a_promote_on_hit: assert property (@(posedge clk) disable iff (reset)
    (update && (cmd == UPD_PROMOTE)) |-> found);

endmodule

// File: cache_pkg.sv
package cache_pkg;

`include "cache_defs.svh"

  //////////////////////////////////////////////////
  // Request and command types
  //////////////////////////////////////////////////

  // One access as seen by both tag stores
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic               is_write;
  } access_req_t;

  // What a level does to the looked-up set at update
  typedef enum logic [1:0] {
    UPD_NONE,
    UPD_FILL,
    UPD_PROMOTE
  } update_cmd_e;

  //////////////////////////////////////////////////
  // Statistics types
  //////////////////////////////////////////////////

  // One-cycle increment flags for a counter block
  typedef struct packed {
    logic read;
    logic hit;
    logic miss;
    logic write;
  } level_event_t;

  // Running totals of one level
  typedef struct packed {
    logic [`STAT_W-1:0] reads;
    logic [`STAT_W-1:0] hits;
    logic [`STAT_W-1:0] misses;
    logic [`STAT_W-1:0] writes;
  } level_stats_t;

endpackage

// File: cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

//////////////////////////////////////////////////
// Address and block geometry
//////////////////////////////////////////////////

// Byte address width of one access
`define ADDR_W 32

// Byte offset bits for 64-byte blocks
`define BLOCK_BITS 6

//////////////////////////////////////////////////
// Level geometry
//////////////////////////////////////////////////

// Small and fast first level
`define L1_SETS 16
`define L1_WAYS 2

// Larger second level
`define L2_SETS 64
`define L2_WAYS 4

// Width of each statistics counter
`define STAT_W 18

// ASCII op codes for read and write
`define OP_READ 8'h52
`define OP_WRITE 8'h57

`endif
